/* build.f */
cache_pkg.sv
cache_lru_tree.sv
cache_meta_mem.sv
cache_miss.sv
cache_dma.sv
cache_miss_top.sv
tb_cache_miss.sv

/* Makefile */
# Verilator build and run of the cache miss testbench.
SRCS = $(shell cat build.f)

obj_dir/Vtb_cache_miss: build.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module tb_cache_miss -f build.f -o Vtb_cache_miss

compile: obj_dir/Vtb_cache_miss

run: compile
	./obj_dir/Vtb_cache_miss

clean:
	rm -rf obj_dir

.PHONY: compile run clean

/* tb_cache_miss.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed testbench for the cache miss path.
// plays the memory and checks against a metadata model.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_cache_miss
  import cache_pkg::*;
();

  logic clk_i;
  logic reset_i;
  logic req_i;
  miss_req_s miss_req_i;
  logic done_o;
  logic hit_o;
  logic [1:0] way_o;
  logic mem_req_o;
  mem_req_s mem_o;
  logic mem_ack_i;

  int seed;
  mem_req_s log_q[$];
  mem_req_s exp_q[$];

  // reference metadata, eight sets of four ways.
  logic [8:0] m_tag [8][4];
  logic m_valid [8][4];
  logic m_lock [8][4];
  logic m_dirty [8][4];
  logic [2:0] m_lru [8];

  cache_miss_top #(
    .ways_p(4),
    .sets_p(8)
  ) cache_miss_top_i (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .req_i(req_i),
    .miss_req_i(miss_req_i),
    .done_o(done_o),
    .hit_o(hit_o),
    .way_o(way_o),
    .mem_req_o(mem_req_o),
    .mem_o(mem_o),
    .mem_ack_i(mem_ack_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Fail %s: got %h, expected %h", name, got, exp));
    end
  endtask

  // memory model, acks each word after a random number of cycles.
  initial begin
    int delay;
    int wait_cnt;
    mem_req_s ent;
    mem_ack_i = 1'b0;
    seed = 18;
    forever begin
      @(posedge clk_i);
      #2;
      if (mem_req_o === 1'b1) begin
        ent = mem_o;
        log_q.push_back(ent);
        delay = $random(seed) & 3;
        repeat (delay) begin
          @(posedge clk_i);
          #2;
        end
        mem_ack_i = 1'b1;
        wait_cnt = 0;
        while (mem_req_o) begin
          @(posedge clk_i);
          #2;
          wait_cnt++;
          if (wait_cnt > 20) begin
            stop_on_error("memory request stayed high after ack");
          end
        end
        mem_ack_i = 1'b0;
      end
    end
  end

  // root bit picks the half, the node below it picks the way.
  function automatic logic [1:0] plru_way(input logic [2:0] bits);
    if (bits[0]) begin
      return {1'b1, bits[2]};
    end
    return {1'b0, bits[1]};
  endfunction

  // point every node on the way's path away from it.
  function automatic logic [2:0] plru_touch(input logic [2:0] bits, input logic [1:0] way);
    logic [2:0] next;
    next = bits;
    next[0] = ~way[1];
    if (way[1]) begin
      next[2] = ~way[0];
    end else begin
      next[1] = ~way[0];
    end
    return next;
  endfunction

  task automatic expect_block(input logic [15:0] base, input logic write);
    mem_req_s ent;
    for (int i = 0; i < 4; i++) begin
      ent.write = write;
      ent.addr = base + 16'(4 * i);
      exp_q.push_back(ent);
    end
  endtask

  task automatic model_op(input cache_op_e op, input logic [15:0] addr,
                          output logic hit, output logic [1:0] way);
    logic [8:0] tag;
    logic [2:0] idx;
    logic [1:0] hit_way;
    logic [1:0] victim;
    logic found;
    tag = addr[15:7];
    idx = addr[6:4];
    hit = 1'b0;
    hit_way = 2'd0;
    found = 1'b0;
    victim = 2'd0;
    for (int w = 3; w >= 0; w--) begin
      if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
        hit = 1'b1;
        hit_way = 2'(w);
      end
      if (!m_valid[idx][w] && !m_lock[idx][w]) begin
        found = 1'b1;
        victim = 2'(w);
      end
    end
    if (!found) begin
      victim = plru_way(m_lru[idx]);
      if (m_lock[idx][victim]) begin
        for (int w = 3; w >= 0; w--) begin
          if (!m_lock[idx][w]) begin
            victim = 2'(w);
          end
        end
      end
    end
    way = hit ? hit_way : victim;
    if (hit) begin
      case (op)
        op_load, op_store: begin
          m_lru[idx] = plru_touch(m_lru[idx], hit_way);
          if (op == op_store) begin
            m_dirty[idx][hit_way] = 1'b1;
          end
        end
        op_alock: m_lock[idx][hit_way] = 1'b1;
        op_aunlock: m_lock[idx][hit_way] = 1'b0;
        op_afl: begin
          if (m_dirty[idx][hit_way]) begin
            expect_block({tag, idx, 4'b0000}, 1'b1);
            m_dirty[idx][hit_way] = 1'b0;
          end
        end
        op_ainv: begin
          m_valid[idx][hit_way] = 1'b0;
          m_lock[idx][hit_way] = 1'b0;
          m_dirty[idx][hit_way] = 1'b0;
        end
        default: begin
        end
      endcase
    end else if (op == op_load || op == op_store || op == op_alock) begin
      if (m_valid[idx][victim] && m_dirty[idx][victim]) begin
        expect_block({m_tag[idx][victim], idx, 4'b0000}, 1'b1);
      end
      expect_block({tag, idx, 4'b0000}, 1'b0);
      m_tag[idx][victim] = tag;
      m_valid[idx][victim] = 1'b1;
      m_lock[idx][victim] = (op == op_alock);
      m_dirty[idx][victim] = (op == op_store);
      m_lru[idx] = plru_touch(m_lru[idx], victim);
    end
  endtask

  // one four-phase request, starts and ends 2 ns after an edge.
  task automatic run_op(input cache_op_e op, input logic [15:0] addr,
                        output logic got_hit, output logic [1:0] got_way, output int cycles);
    int wait_cnt;
    miss_req_i.op = op;
    miss_req_i.addr = addr;
    req_i = 1'b1;
    cycles = 0;
    while (!done_o) begin
      @(posedge clk_i);
      #2;
      cycles++;
      if (cycles > 400) begin
        stop_on_error("timeout waiting for done_o to rise");
      end
    end
    got_hit = hit_o;
    got_way = way_o;
    req_i = 1'b0;
    wait_cnt = 0;
    while (done_o) begin
      @(posedge clk_i);
      #2;
      wait_cnt++;
      if (wait_cnt > 10) begin
        stop_on_error("timeout waiting for done_o to fall");
      end
    end
  endtask

  task automatic check_traffic();
    check_val("memory transfer count", 32'(log_q.size()), 32'(exp_q.size()));
    foreach (exp_q[i]) begin
      check_val("mem_o.addr", 32'(log_q[i].addr), 32'(exp_q[i].addr));
      check_val("mem_o.write", 32'(log_q[i].write), 32'(exp_q[i].write));
    end
    log_q.delete();
    exp_q.delete();
  endtask

  task automatic do_op(input cache_op_e op, input logic [8:0] tag, input logic [2:0] idx,
                       output logic [1:0] got_way, output int cycles);
    logic exp_hit;
    logic [1:0] exp_way;
    logic got_hit;
    logic [15:0] addr;
    addr = {tag, idx, 4'b0000};
    model_op(op, addr, exp_hit, exp_way);
    run_op(op, addr, got_hit, got_way, cycles);
    check_val("hit_o", 32'(got_hit), 32'(exp_hit));
    check_val("way_o", 32'(got_way), 32'(exp_way));
    check_traffic();
  endtask

  task automatic test_load_miss_hit();
    logic [1:0] way;
    int cycles;
    do_op(op_load, 9'd5, 3'd2, way, cycles);
    check_val("way_o", 32'(way), 32'd0);
    do_op(op_load, 9'd5, 3'd2, way, cycles);
    check_val("way_o", 32'(way), 32'd0);
    check_val("hit latency", 32'(cycles), 32'd3);
  endtask

  task automatic test_plru_replace();
    logic [1:0] way;
    int cycles;
    for (int t = 0; t < 4; t++) begin
      do_op(op_load, 9'(t + 1), 3'd3, way, cycles);
      check_val("way_o", 32'(way), 32'(t));
    end
    do_op(op_load, 9'd9, 3'd3, way, cycles);
    do_op(op_load, 9'd2, 3'd3, way, cycles);
    do_op(op_load, 9'd10, 3'd3, way, cycles);
  endtask

  task automatic test_dirty_evict();
    logic [1:0] way;
    int cycles;
    do_op(op_store, 9'd7, 3'd4, way, cycles);
    for (int t = 8; t < 11; t++) begin
      do_op(op_load, 9'(t), 3'd4, way, cycles);
    end
    // pseudo-LRU now points back at the stored line.
    do_op(op_load, 9'd11, 3'd4, way, cycles);
    check_val("way_o", 32'(way), 32'd0);
  endtask

  task automatic test_flush_inval();
    logic [1:0] way;
    int cycles;
    do_op(op_store, 9'd3, 3'd5, way, cycles);
    do_op(op_afl, 9'd3, 3'd5, way, cycles);
    do_op(op_load, 9'd3, 3'd5, way, cycles);
    do_op(op_store, 9'd3, 3'd5, way, cycles);
    do_op(op_ainv, 9'd3, 3'd5, way, cycles);
    do_op(op_load, 9'd3, 3'd5, way, cycles);
  endtask

  task automatic test_lock_unlock();
    logic [1:0] way;
    int cycles;
    logic reused;
    do_op(op_alock, 9'd20, 3'd6, way, cycles);
    for (int t = 21; t < 28; t++) begin
      do_op(op_load, 9'(t), 3'd6, way, cycles);
      check_val("way_o not locked way", 32'(way != 2'd0), 32'd1);
    end
    do_op(op_aunlock, 9'd20, 3'd6, way, cycles);
    reused = 1'b0;
    for (int t = 28; t < 32; t++) begin
      do_op(op_load, 9'(t), 3'd6, way, cycles);
      if (way == 2'd0) begin
        reused = 1'b1;
      end
    end
    check_val("unlocked way reused", 32'(reused), 32'd1);
  endtask

  initial begin
    reset_i = 1'b1;
    req_i = 1'b0;
    miss_req_i = '0;
    for (int s = 0; s < 8; s++) begin
      m_lru[s] = 3'b000;
      for (int w = 0; w < 4; w++) begin
        m_tag[s][w] = 9'd0;
        m_valid[s][w] = 1'b0;
        m_lock[s][w] = 1'b0;
        m_dirty[s][w] = 1'b0;
      end
    end
    repeat (4) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    test_load_miss_hit();
    test_plru_replace();
    test_dirty_evict();
    test_flush_inval();
    test_lock_unlock();
    $display("Done: no errors");
    $finish;
  end

endmodule

/* cache_miss_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top level of the cache miss path.
// request port in, word-level memory port out.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cache_miss_top
  import cache_pkg::*;
#(
  parameter int ways_p = 4,
  parameter int sets_p = 8,
  localparam int idx_w = $clog2(sets_p),
  localparam int way_w = $clog2(ways_p),
  localparam int tag_w = addr_width - word_bytes_lg - block_words_lg - idx_w,
  localparam int meta_w = ways_p * (tag_w + 3) + ways_p - 1
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             req_i,
  input  miss_req_s        miss_req_i,
  output logic             done_o,
  output logic             hit_o,
  output logic [way_w-1:0] way_o,
  output logic             mem_req_o,
  output mem_req_s         mem_o,
  input  logic             mem_ack_i
);

  logic meta_rd, meta_wr;
  logic [idx_w-1:0] meta_index;
  logic [meta_w-1:0] meta_wdata, meta_wmask, meta_rdata;
  dma_cmd_s dma_cmd;
  logic dma_done;

  cache_miss #(
    .ways_p(ways_p),
    .sets_p(sets_p)
  ) cache_miss_i (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .req_i(req_i),
    .miss_req_i(miss_req_i),
    .done_o(done_o),
    .hit_o(hit_o),
    .way_o(way_o),
    .meta_rd_o(meta_rd),
    .meta_wr_o(meta_wr),
    .meta_index_o(meta_index),
    .meta_wdata_o(meta_wdata),
    .meta_wmask_o(meta_wmask),
    .meta_rdata_i(meta_rdata),
    .dma_cmd_o(dma_cmd),
    .dma_done_i(dma_done)
  );

  cache_meta_mem #(
    .ways_p(ways_p),
    .sets_p(sets_p)
  ) cache_meta_mem_i (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .rd_i(meta_rd),
    .wr_i(meta_wr),
    .index_i(meta_index),
    .wdata_i(meta_wdata),
    .wmask_i(meta_wmask),
    .rdata_o(meta_rdata)
  );

  cache_dma cache_dma_i (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .cmd_i(dma_cmd),
    .done_o(dma_done),
    .mem_req_o(mem_req_o),
    .mem_o(mem_o),
    .mem_ack_i(mem_ack_i)
  );

endmodule

/* cache_dma.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMA engine: one block command becomes four word transfers.
// each word is a full four-phase handshake on the memory port.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cache_dma
  import cache_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  dma_cmd_s cmd_i,
  output logic     done_o,
  output logic     mem_req_o,
  output mem_req_s mem_o,
  input  logic     mem_ack_i
);

  typedef enum logic [1:0] {
    d_idle, d_req, d_rel, d_done
  } dma_state_e;

  dma_state_e state_r;
  logic [block_words_lg-1:0] beat_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= d_idle;
      beat_r <= '0;
    end else begin
      case (state_r)
        d_idle: begin
          beat_r <= '0;
          if (cmd_i.cmd != dma_nop) begin
            state_r <= d_req;
          end
        end
        d_req: begin
          if (mem_ack_i) begin
            state_r <= d_rel;
          end
        end
        d_rel: begin
          // wait for ack low before the next beat.
          if (!mem_ack_i) begin
            if (beat_r == '1) begin
              state_r <= d_done;
            end else begin
              beat_r <= beat_r + 1'b1;
              state_r <= d_req;
            end
          end
        end
        default: begin
          state_r <= d_idle;
        end
      endcase
    end
  end

  assign mem_req_o = (state_r == d_req);
  assign done_o = (state_r == d_done);
  assign mem_o.write = (cmd_i.cmd == dma_evict);
  assign mem_o.addr = {cmd_i.block_addr[addr_width-1:word_bytes_lg+block_words_lg],
                       beat_r, {word_bytes_lg{1'b0}}};

  // relies on the miss unit holding its command.
  mem_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_o |=> !mem_req_o || $stable(mem_o));

endmodule

/* cache_miss.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// miss handling FSM for lookup, victim choice, metadata update and DMA sequencing.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cache_miss
  import cache_pkg::*;
#(
  parameter int ways_p = 4,
  parameter int sets_p = 8,
  localparam int idx_w = $clog2(sets_p),
  localparam int way_w = $clog2(ways_p),
  localparam int off_w = word_bytes_lg + block_words_lg,
  localparam int tag_w = addr_width - off_w - idx_w,
  localparam int meta_w = ways_p * (tag_w + 3) + ways_p - 1
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              req_i,
  input  miss_req_s         miss_req_i,
  output logic              done_o,
  output logic              hit_o,
  output logic [way_w-1:0]  way_o,
  output logic              meta_rd_o,
  output logic              meta_wr_o,
  output logic [idx_w-1:0]  meta_index_o,
  output logic [meta_w-1:0] meta_wdata_o,
  output logic [meta_w-1:0] meta_wmask_o,
  input  logic [meta_w-1:0] meta_rdata_i,
  output dma_cmd_s          dma_cmd_o,
  input  logic              dma_done_i
);

  typedef struct packed {
    logic [tag_w-1:0] tag;
    logic valid;
    logic lock;
    logic dirty;
  } way_meta_s;

  typedef struct packed {
    way_meta_s [ways_p-1:0] way;
    logic [ways_p-2:0] lru;
  } set_meta_s;

  typedef enum logic [2:0] {
    s_idle, s_lookup, s_compare, s_evict, s_fill, s_done
  } miss_state_e;

  miss_state_e state_r, state_n;
  miss_req_s req_r;
  logic [way_w-1:0] way_r, way_n;
  logic hit_r, hit_n;
  logic dma_gap_r;
  set_meta_s rmeta, wdata, wmask;
  logic [tag_w-1:0] req_tag;
  logic [idx_w-1:0] req_index;
  logic hit, free_found;
  logic [way_w-1:0] hit_way, free_way, unlocked_way, victim, lru_way, lru_upd_way;
  logic [ways_p-2:0] lru_data, lru_mask;

  assign rmeta = meta_rdata_i;
  assign req_tag = req_r.addr[addr_width-1 -: tag_w];
  assign req_index = req_r.addr[off_w +: idx_w];

  // lowest valid way whose tag matches.
  always_comb begin
    hit = 1'b0;
    hit_way = '0;
    for (int w = ways_p - 1; w >= 0; w--) begin
      if (rmeta.way[w].valid && rmeta.way[w].tag == req_tag) begin
        hit = 1'b1;
        hit_way = way_w'(w);
      end
    end
  end

  // invalid and unlocked first, then pseudo-LRU, then lowest unlocked.
  always_comb begin
    free_found = 1'b0;
    free_way = '0;
    unlocked_way = '0;
    for (int w = ways_p - 1; w >= 0; w--) begin
      if (!rmeta.way[w].valid && !rmeta.way[w].lock) begin
        free_found = 1'b1;
        free_way = way_w'(w);
      end
      if (!rmeta.way[w].lock) begin
        unlocked_way = way_w'(w);
      end
    end
    if (free_found) begin
      victim = free_way;
    end else if (!rmeta.way[lru_way].lock) begin
      victim = lru_way;
    end else begin
      victim = unlocked_way;
    end
  end

  // hits update the hit way and fills update the latched victim.
  assign lru_upd_way = (state_r == s_compare) ? hit_way : way_r;

  cache_lru_tree #(
    .ways_p(ways_p)
  ) cache_lru_tree_i (
    .lru_i(rmeta.lru),
    .way_i(lru_upd_way),
    .lru_way_o(lru_way),
    .lru_data_o(lru_data),
    .lru_mask_o(lru_mask)
  );

  always_comb begin
    state_n = state_r;
    way_n = way_r;
    hit_n = hit_r;
    meta_rd_o = 1'b0;
    meta_wr_o = 1'b0;
    wdata = '0;
    wmask = '0;
    dma_cmd_o.cmd = dma_nop;
    dma_cmd_o.block_addr = '0;
    case (state_r)
      s_idle: begin
        if (req_i) begin
          state_n = s_lookup;
        end
      end
      s_lookup: begin
        meta_rd_o = 1'b1;
        state_n = s_compare;
      end
      s_compare: begin
        hit_n = hit;
        way_n = hit ? hit_way : victim;
        state_n = s_done;
        meta_wr_o = hit;
        case (req_r.op)
          op_load, op_store: begin
            wdata.lru = lru_data;
            wmask.lru = lru_mask;
            wdata.way[hit_way].dirty = 1'b1;
            wmask.way[hit_way].dirty = (req_r.op == op_store);
          end
          op_alock, op_aunlock: begin
            wdata.way[hit_way].lock = (req_r.op == op_alock);
            wmask.way[hit_way].lock = 1'b1;
          end
          op_afl: begin
            // dirty bit is cleared once the write-back finishes.
            meta_wr_o = 1'b0;
            if (hit && rmeta.way[hit_way].dirty) begin
              state_n = s_evict;
            end
          end
          default: begin
            // ainv drops the line and its dirty data.
            wmask.way[hit_way].valid = 1'b1;
            wmask.way[hit_way].lock = 1'b1;
            wmask.way[hit_way].dirty = 1'b1;
          end
        endcase
        if (!hit && (req_r.op == op_load || req_r.op == op_store ||
                     req_r.op == op_alock)) begin
          state_n = (rmeta.way[victim].valid && rmeta.way[victim].dirty) ? s_evict : s_fill;
        end
      end
      s_evict: begin
        dma_cmd_o.cmd = dma_gap_r ? dma_nop : dma_evict;
        dma_cmd_o.block_addr = {rmeta.way[way_r].tag, req_index, {off_w{1'b0}}};
        if (dma_done_i) begin
          if (req_r.op == op_afl) begin
            meta_wr_o = 1'b1;
            wmask.way[way_r].dirty = 1'b1;
            state_n = s_done;
          end else begin
            state_n = s_fill;
          end
        end
      end
      s_fill: begin
        dma_cmd_o.cmd = dma_gap_r ? dma_nop : dma_fill;
        dma_cmd_o.block_addr = {req_tag, req_index, {off_w{1'b0}}};
        if (dma_done_i) begin
          meta_wr_o = 1'b1;
          wdata.way[way_r].tag = req_tag;
          wdata.way[way_r].valid = 1'b1;
          wdata.way[way_r].lock = (req_r.op == op_alock);
          wdata.way[way_r].dirty = (req_r.op == op_store);
          wmask.way[way_r] = '1;
          wdata.lru = lru_data;
          wmask.lru = lru_mask;
          state_n = s_done;
        end
      end
      s_done: begin
        if (!req_i) begin
          state_n = s_idle;
        end
      end
      default: begin
        state_n = s_idle;
      end
    endcase
  end

  assign meta_index_o = req_index;
  assign meta_wdata_o = wdata;
  assign meta_wmask_o = wmask;
  assign done_o = (state_r == s_done);
  assign hit_o = hit_r;
  assign way_o = way_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= s_idle;
      way_r <= '0;
      hit_r <= 1'b0;
      dma_gap_r <= 1'b0;
    end else begin
      state_r <= state_n;
      way_r <= way_n;
      hit_r <= hit_n;
      // forces one nop cycle between back-to-back block commands.
      dma_gap_r <= dma_done_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_r == s_idle && req_i) begin
      req_r <= miss_req_i;
    end
  end

  // needs at least one unlocked way in the set.
  victim_unlocked_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_r == s_compare && !hit && (state_n == s_evict || state_n == s_fill))
      |-> !rmeta.way[victim].lock);

  dma_cmd_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (dma_cmd_o.cmd != dma_nop && !dma_done_i) |=> $stable(dma_cmd_o));

endmodule

/* cache_meta_mem.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tag and status storage with one flat word per set.
// one-cycle read and bit-masked write.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cache_meta_mem
  import cache_pkg::*;
#(
  parameter int ways_p = 4,
  parameter int sets_p = 8,
  localparam int idx_w = $clog2(sets_p),
  localparam int tag_w = addr_width - word_bytes_lg - block_words_lg - idx_w,
  localparam int slot_w = tag_w + 3,
  localparam int meta_w = ways_p * slot_w + ways_p - 1
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              rd_i,
  input  logic              wr_i,
  input  logic [idx_w-1:0]  index_i,
  input  logic [meta_w-1:0] wdata_i,
  input  logic [meta_w-1:0] wmask_i,
  output logic [meta_w-1:0] rdata_o
);

  // way slots {tag, valid, lock, dirty} from the msb down, then the lru bits.
  logic [meta_w-1:0] mem_r [sets_p];

  // tags survive reset and all status bits are cleared.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < sets_p; s++) begin
        mem_r[s][ways_p-2:0] <= '0;
        for (int w = 0; w < ways_p; w++) begin
          mem_r[s][ways_p-1 + w*slot_w +: 3] <= '0;
        end
      end
    end else if (wr_i) begin
      mem_r[index_i] <= (mem_r[index_i] & ~wmask_i) | (wdata_i & wmask_i);
    end
  end

  // read data holds until the next read.
  always_ff @(posedge clk_i) begin
    if (rd_i) begin
      rdata_o <= mem_r[index_i];
    end
  end

endmodule

/* cache_lru_tree.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tree pseudo-LRU encode and update for one set.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cache_lru_tree #(
  parameter int ways_p = 4,
  localparam int way_w = $clog2(ways_p)
) (
  input  logic [ways_p-2:0] lru_i,
  input  logic [way_w-1:0]  way_i,
  output logic [way_w-1:0]  lru_way_o,
  output logic [ways_p-2:0] lru_data_o,
  output logic [ways_p-2:0] lru_mask_o
);

  // nodes are heap ordered, node n has children 2n+1 and 2n+2.
  // a node bit of 1 means the least recent way is in the upper half.

  // walk from the root, following the bits toward the LRU way.
  always_comb begin
    int enc_node;
    enc_node = 0;
    lru_way_o = '0;
    for (int lvl = 0; lvl < way_w; lvl++) begin
      lru_way_o[way_w-1-lvl] = lru_i[enc_node];
      enc_node = 2 * enc_node + 1 + int'(lru_i[enc_node]);
    end
  end

  // every node on the path of way_i is turned to point away from it.
  always_comb begin
    int upd_node;
    upd_node = 0;
    lru_data_o = '0;
    lru_mask_o = '0;
    for (int lvl = 0; lvl < way_w; lvl++) begin
      lru_mask_o[upd_node] = 1'b1;
      lru_data_o[upd_node] = ~way_i[way_w-1-lvl];
      upd_node = 2 * upd_node + 1 + int'(way_i[way_w-1-lvl]);
    end
  end

endmodule

/* cache_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types and address geometry for the cache miss path.
// modules pull these in with a wildcard import.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package cache_pkg;

  // byte address width of the request and memory ports.
  localparam int addr_width = 16;

  // 32-bit words, four words per block.
  localparam int word_bytes_lg = 2;
  localparam int block_words_lg = 2;

  // operations accepted on the request port.
  typedef enum logic [2:0] {
    op_load,
    op_store,
    op_afl,
    op_ainv,
    op_alock,
    op_aunlock
  } cache_op_e;

  // block commands from the miss unit to the DMA engine.
  typedef enum logic [1:0] {
    dma_nop,
    dma_evict,
    dma_fill
  } dma_cmd_e;

  typedef struct packed {
    cache_op_e op;
    logic [addr_width-1:0] addr;
  } miss_req_s;

  // one word transfer on the external memory port.
  typedef struct packed {
    logic write;
    logic [addr_width-1:0] addr;
  } mem_req_s;

  // block address always has a zero block offset.
  typedef struct packed {
    dma_cmd_e cmd;
    logic [addr_width-1:0] block_addr;
  } dma_cmd_s;

endpackage
